/* src/rc5Pkg.sv */
`default_nettype none

package rc5Pkg;

    // Word, block and key widths
    typedef logic [31:0]  word_t;
    typedef logic [63:0]  block_t;
    typedef logic [127:0] key_t;

    // Only the low five bits of a word steer a rotate
    typedef logic [4:0]   rotAmt_t;

    // User key length in words
    localparam int KEY_WORDS = 4;

    // Magic constants of the RC5-32 schedule
    localparam word_t P32 = 32'hB7E15163;
    localparam word_t Q32 = 32'h9E3779B9;

    // Key schedule states
    typedef enum logic [1:0] {
        KEY_IDLE,
        KEY_LOAD,
        KEY_MIX,
        KEY_DONE
    } keyState_t;

    ////////////////////////////////////////////////////
    // Rotates
    ////////////////////////////////////////////////////

    // Left rotate, upper half of the doubled word after the shift
    function automatic word_t rotl(input word_t value, input word_t amount);
        rotAmt_t     shift;
        logic [63:0] doubled;
        shift   = amount[4:0];
        doubled = {value, value} << shift;
        return doubled[63:32];
    endfunction

    // Right rotate, lower half of the doubled word after the shift
    function automatic word_t rotr(input word_t value, input word_t amount);
        rotAmt_t     shift;
        logic [63:0] doubled;
        shift   = amount[4:0];
        doubled = {value, value} >> shift;
        return doubled[31:0];
    endfunction

endpackage

`default_nettype wire

/* src/rc5RoundIf.sv */
`default_nettype none

interface rc5RoundIf;
    import rc5Pkg::*;

    // One block slot between two pipeline stages
    logic  valid;
    logic  decrypt;
    word_t a;
    word_t b;

    modport src (
        output valid,
        output decrypt,
        output a,
        output b
    );

    modport dst (
        input valid,
        input decrypt,
        input a,
        input b
    );

endinterface

`default_nettype wire

/* src/rc5KeySchedule.sv */
`default_nettype none

module rc5KeySchedule #(
    parameter  int ROUNDS  = 12,
    localparam int SUBKEYS = 2 * ROUNDS + 2
) (
    input  wire                 clk,
    input  wire                 clr,
    input  wire                 i_keyReq,
    input  wire rc5Pkg::key_t   i_key,
    output logic                o_keyAck,
    output logic                o_keyReady,
    output rc5Pkg::word_t       o_subkeys [SUBKEYS]
);
    import rc5Pkg::*;

    // Three passes over the longer of the table and the key
    localparam int MIX_STEPS = 3 * ((SUBKEYS > KEY_WORDS) ? SUBKEYS : KEY_WORDS);
    localparam int IDX_W     = $clog2(SUBKEYS);
    localparam int KEY_IDX_W = $clog2(KEY_WORDS);
    localparam int STEP_W    = $clog2(MIX_STEPS);

    keyState_t            state;
    logic                 keyReady;
    logic [IDX_W-1:0]     tabIdx;
    logic [KEY_IDX_W-1:0] keyIdx;
    logic [STEP_W-1:0]    stepCnt;
    logic                 lastStep;

    key_t                 keyReg;
    word_t                lWords [KEY_WORDS];
    word_t                subkeyTable [SUBKEYS];
    word_t                regA;
    word_t                regB;
    word_t                mixA;
    word_t                mixB;

    ////////////////////////////////////////////////////
    // One mixing step
    ////////////////////////////////////////////////////

    always_comb begin
        mixA = rotl(subkeyTable[tabIdx] + regA + regB, 32'd3);
        mixB = rotl(lWords[keyIdx] + mixA + regB, mixA + regB);
    end

    assign lastStep = (stepCnt == STEP_W'(MIX_STEPS - 1));

    ////////////////////////////////////////////////////
    // Handshake FSM and subkey table
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            state    <= KEY_IDLE;
            keyReady <= 1'b0;
            tabIdx   <= '0;
            keyIdx   <= '0;
            stepCnt  <= '0;
            for (int k = 0; k < SUBKEYS; k++) begin
                subkeyTable[k] <= '0;
            end
        end else begin
            case (state)
                KEY_IDLE: begin
                    if (i_keyReq) begin
                        state    <= KEY_LOAD;
                        keyReady <= 1'b0;
                    end
                end
                KEY_LOAD: begin
                    // Arithmetic progression seeded with P32
                    for (int k = 0; k < SUBKEYS; k++) begin
                        subkeyTable[k] <= P32 + word_t'(k) * Q32;
                    end
                    tabIdx  <= '0;
                    keyIdx  <= '0;
                    stepCnt <= '0;
                    state   <= KEY_MIX;
                end
                KEY_MIX: begin
                    subkeyTable[tabIdx] <= mixA;
                    if (tabIdx == IDX_W'(SUBKEYS - 1)) begin
                        tabIdx <= '0;
                    end else begin
                        tabIdx <= tabIdx + 1'b1;
                    end
                    keyIdx  <= keyIdx + 1'b1;
                    stepCnt <= stepCnt + 1'b1;
                    if (lastStep) begin
                        state    <= KEY_DONE;
                        keyReady <= 1'b1;
                    end
                end
                KEY_DONE: begin
                    // Hold the ack until the host drops its request
                    if (!i_keyReq) begin
                        state <= KEY_IDLE;
                    end
                end
                default: state <= KEY_IDLE;
            endcase
        end
    end

    // Key words and mixing accumulators
    always_ff @(posedge clk) begin
        if (state == KEY_IDLE && i_keyReq) begin
            keyReg <= i_key;
        end
        if (state == KEY_LOAD) begin
            for (int k = 0; k < KEY_WORDS; k++) begin
                lWords[k] <= keyReg[32*k +: 32];
            end
            regA <= '0;
            regB <= '0;
        end else if (state == KEY_MIX) begin
            lWords[keyIdx] <= mixB;
            regA           <= mixA;
            regB           <= mixB;
        end
    end

    assign o_keyAck   = (state == KEY_DONE);
    assign o_keyReady = keyReady;
    assign o_subkeys  = subkeyTable;

endmodule

`default_nettype wire

/* src/rc5Round.sv */
`default_nettype none

module rc5Round #(
    parameter  int ROUNDS      = 12,
    parameter  int ROUND_INDEX = 1,
    localparam int SUBKEYS     = 2 * ROUNDS + 2
) (
    input  wire           clk,
    input  wire           clr,
    input  wire rc5Pkg::word_t i_subkeys [SUBKEYS],
    rc5RoundIf.dst        up,
    rc5RoundIf.src        down
);
    import rc5Pkg::*;

    // Encrypt walks rounds upward, decrypt walks them back down
    localparam int ENC_ROUND = ROUND_INDEX;
    localparam int DEC_ROUND = ROUNDS + 1 - ROUND_INDEX;

    word_t encA;
    word_t encB;
    word_t decA;
    word_t decB;

    // Encrypt round
    always_comb begin
        encA = rotl(up.a ^ up.b, up.b) + i_subkeys[2*ENC_ROUND];
        encB = rotl(up.b ^ encA, encA) + i_subkeys[2*ENC_ROUND+1];
    end

    // Decrypt round, B is undone first
    always_comb begin
        decB = rotr(up.b - i_subkeys[2*DEC_ROUND+1], up.a) ^ up.a;
        decA = rotr(up.a - i_subkeys[2*DEC_ROUND], decB) ^ decB;
    end

    ////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            down.valid   <= 1'b0;
            down.decrypt <= 1'b0;
        end else begin
            down.valid   <= up.valid;
            down.decrypt <= up.decrypt;
        end
    end

    // Words only move with a live block
    always_ff @(posedge clk) begin
        if (up.valid) begin
            if (up.decrypt) begin
                down.a <= decA;
                down.b <= decB;
            end else begin
                down.a <= encA;
                down.b <= encB;
            end
        end
    end

endmodule

`default_nettype wire

/* src/rc5Pipeline.sv */
`default_nettype none

module rc5Pipeline #(
    parameter  int ROUNDS  = 12,
    localparam int SUBKEYS = 2 * ROUNDS + 2
) (
    input  wire                  clk,
    input  wire                  clr,
    input  wire rc5Pkg::word_t   i_subkeys [SUBKEYS],
    input  wire                  i_keyReady,
    input  wire                  i_valid,
    input  wire                  i_decrypt,
    input  wire rc5Pkg::block_t  i_block,
    output logic                 o_valid,
    output logic                 o_decrypt,
    output rc5Pkg::block_t       o_block
);
    import rc5Pkg::*;

    // Slot 0 is the input register, slot k the output of round stage k
    rc5RoundIf stageIf [ROUNDS+1] ();

    logic  accept;
    logic  inValid;
    logic  inDecrypt;
    word_t inA;
    word_t inB;

    logic  lastValid;
    logic  lastDecrypt;
    word_t lastA;
    word_t lastB;

    ////////////////////////////////////////////////////
    // Input register with pre-round whitening
    ////////////////////////////////////////////////////

    // Blocks are dropped until a key is in place
    assign accept = i_valid && i_keyReady;

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            inValid   <= 1'b0;
            inDecrypt <= 1'b0;
        end else begin
            inValid   <= accept;
            inDecrypt <= i_decrypt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (i_decrypt) begin
                inA <= i_block[63:32];
                inB <= i_block[31:0];
            end else begin
                inA <= i_block[63:32] + i_subkeys[0];
                inB <= i_block[31:0] + i_subkeys[1];
            end
        end
    end

    assign stageIf[0].valid   = inValid;
    assign stageIf[0].decrypt = inDecrypt;
    assign stageIf[0].a       = inA;
    assign stageIf[0].b       = inB;

    // Round stages
    for (genvar k = 1; k <= ROUNDS; k++) begin : g_round
        rc5Round #(
            .ROUNDS      (ROUNDS),
            .ROUND_INDEX (k)
        ) u_round (
            .clk       (clk),
            .clr       (clr),
            .i_subkeys (i_subkeys),
            .up        (stageIf[k-1]),
            .down      (stageIf[k])
        );
    end

    ////////////////////////////////////////////////////
    // Output register with post-round unwhitening
    ////////////////////////////////////////////////////

    assign lastValid   = stageIf[ROUNDS].valid;
    assign lastDecrypt = stageIf[ROUNDS].decrypt;
    assign lastA       = stageIf[ROUNDS].a;
    assign lastB       = stageIf[ROUNDS].b;

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            o_valid   <= 1'b0;
            o_decrypt <= 1'b0;
        end else begin
            o_valid   <= lastValid;
            o_decrypt <= lastDecrypt;
        end
    end

    always_ff @(posedge clk) begin
        if (lastValid) begin
            if (lastDecrypt) begin
                o_block <= {lastA - i_subkeys[0], lastB - i_subkeys[1]};
            end else begin
                o_block <= {lastA, lastB};
            end
        end
    end

endmodule

`default_nettype wire

/* src/rc5Cipher.sv */
`default_nettype none

module rc5Cipher #(
    parameter int ROUNDS = 12
) (
    input  wire                  clk,
    input  wire                  clr,

    // Key loading, four-phase req/ack
    input  wire                  i_keyReq,
    input  wire rc5Pkg::key_t    i_key,
    output logic                 o_keyAck,
    output logic                 o_keyReady,

    // Block stream, fixed latency
    input  wire                  i_valid,
    input  wire                  i_decrypt,
    input  wire rc5Pkg::block_t  i_block,
    output logic                 o_valid,
    output logic                 o_decrypt,
    output rc5Pkg::block_t       o_block
);
    import rc5Pkg::*;

    localparam int SUBKEYS = 2 * ROUNDS + 2;

    // Expanded key shared by every stage
    word_t subkeys [SUBKEYS];

    rc5KeySchedule #(
        .ROUNDS (ROUNDS)
    ) u_rc5KeySchedule (
        .clk        (clk),
        .clr        (clr),
        .i_keyReq   (i_keyReq),
        .i_key      (i_key),
        .o_keyAck   (o_keyAck),
        .o_keyReady (o_keyReady),
        .o_subkeys  (subkeys)
    );

    rc5Pipeline #(
        .ROUNDS (ROUNDS)
    ) u_rc5Pipeline (
        .clk        (clk),
        .clr        (clr),
        .i_subkeys  (subkeys),
        .i_keyReady (o_keyReady),
        .i_valid    (i_valid),
        .i_decrypt  (i_decrypt),
        .i_block    (i_block),
        .o_valid    (o_valid),
        .o_decrypt  (o_decrypt),
        .o_block    (o_block)
    );

endmodule

`default_nettype wire

/* verif/rc5Model.svh */
`ifndef RC5_MODEL_SVH
`define RC5_MODEL_SVH

// RC5-32 reference working on its own copy of the subkey table
localparam logic [31:0] MODEL_P32 = 32'hB7E15163;
localparam logic [31:0] MODEL_Q32 = 32'h9E3779B9;

logic [31:0] modelS [SUBKEYS];

function automatic logic [31:0] leftRot(input logic [31:0] x, input logic [31:0] n);
    int s;
    s = int'(n[4:0]);
    if (s == 0) begin
        return x;
    end
    return (x << s) | (x >> (32 - s));
endfunction

function automatic logic [31:0] rightRot(input logic [31:0] x, input logic [31:0] n);
    int s;
    s = int'(n[4:0]);
    if (s == 0) begin
        return x;
    end
    return (x >> s) | (x << (32 - s));
endfunction

// Standard schedule, key word j taken from bits 32j+31 down to 32j
task automatic expandModelKey(input logic [127:0] key);
    logic [31:0] l [4];
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    int          j;
    for (int k = 0; k < 4; k++) begin
        l[k] = key[32*k +: 32];
    end
    modelS[0] = MODEL_P32;
    for (int k = 1; k < SUBKEYS; k++) begin
        modelS[k] = modelS[k-1] + MODEL_Q32;
    end
    a = '0;
    b = '0;
    i = 0;
    j = 0;
    for (int k = 0; k < MIX_STEPS; k++) begin
        a         = leftRot(modelS[i] + a + b, 32'd3);
        modelS[i] = a;
        b         = leftRot(l[j] + a + b, a + b);
        l[j]      = b;
        i         = (i + 1) % SUBKEYS;
        j         = (j + 1) % 4;
    end
endtask

function automatic logic [63:0] encryptModel(input logic [63:0] plain);
    logic [31:0] a;
    logic [31:0] b;
    a = plain[63:32] + modelS[0];
    b = plain[31:0] + modelS[1];
    for (int r = 1; r <= ROUNDS; r++) begin
        a = leftRot(a ^ b, b) + modelS[2*r];
        b = leftRot(b ^ a, a) + modelS[2*r+1];
    end
    return {a, b};
endfunction

function automatic logic [63:0] decryptModel(input logic [63:0] cipher);
    logic [31:0] a;
    logic [31:0] b;
    a = cipher[63:32];
    b = cipher[31:0];
    for (int r = ROUNDS; r >= 1; r--) begin
        b = rightRot(b - modelS[2*r+1], a) ^ a;
        a = rightRot(a - modelS[2*r], b) ^ b;
    end
    return {a - modelS[0], b - modelS[1]};
endfunction

`endif

/* verif/rc5CipherTb.sv */
`default_nettype none

module rc5CipherTb;

    localparam int ROUNDS     = 12;
    localparam int SUBKEYS    = 2 * ROUNDS + 2;
    localparam int MIX_STEPS  = 3 * ((SUBKEYS > 4) ? SUBKEYS : 4);
    localparam int KEY_CYCLES = MIX_STEPS + 2;
    localparam int LATENCY    = ROUNDS + 2;
    localparam int CLK_PERIOD = 40;
    localparam int STREAM_LEN = 40;
    localparam int BLOCKS     = 2 + 8 + 6 + STREAM_LEN + 8;
    localparam int WATCHDOG   = 2 * (4 * (KEY_CYCLES + 12) + BLOCKS + 7 * (LATENCY + 4));

    logic         clk;
    logic         clr;
    logic         i_keyReq;
    logic [127:0] i_key;
    logic         o_keyAck;
    logic         o_keyReady;
    logic         i_valid;
    logic         i_decrypt;
    logic [63:0]  i_block;
    logic         o_valid;
    logic         o_decrypt;
    logic [63:0]  o_block;

    string        testName = "init";
    int           errCount = 0;
    int           testErrs = 0;
    int           passCount = 0;
    int           failCount = 0;
    int           cycleCount = 0;

    // Blocks in flight with the oldest first
    logic [63:0]  expBlock [$];
    logic         expMode [$];
    int           expDue [$];

    `include "rc5Model.svh"

    rc5Cipher #(.ROUNDS(ROUNDS)) u_rc5Cipher (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d cycles", WATCHDOG);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Result monitor sampling on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin : resultMonitor
        if (o_valid) begin
            assert (expDue.size() != 0) else begin
                $display("[ERROR] %s: o_valid with no block in flight", testName);
                errCount++;
            end
        end
        if (o_valid && expDue.size() != 0) begin
            assert (expDue[0] == cycleCount) else begin
                $display("[ERROR] %s: result at cycle %0d, due at cycle %0d",
                         testName, cycleCount, expDue[0]);
                errCount++;
            end
            assert (o_block === expBlock[0]) else begin
                $display("[FAIL] %s o_block: expected %h, actual %h",
                         testName, expBlock[0], o_block);
                errCount++;
            end
            checkBit("o_decrypt", expMode[0], o_decrypt);
            dropOldest();
        end else if (expDue.size() != 0) begin
            assert (expDue[0] > cycleCount) else begin
                $display("[ERROR] %s: no result by cycle %0d", testName, cycleCount);
                errCount++;
            end
            if (expDue[0] <= cycleCount) begin
                dropOldest();
            end
        end
        cycleCount = cycleCount + 1;
    end

    task automatic dropOldest();
        void'(expBlock.pop_front());
        void'(expMode.pop_front());
        void'(expDue.pop_front());
    endtask

    task automatic checkBit(input string what, input logic want, input logic got);
        assert (got === want) else begin
            $display("[FAIL] %s %s: expected %0b, actual %0b", testName, what, want, got);
            errCount++;
        end
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrs = errCount;
    endtask

    task automatic endTest();
        if (errCount == testErrs) begin
            passCount++;
            $display("%s: passed", testName);
        end else begin
            failCount++;
            $display("%s: %0d errors", testName, errCount - testErrs);
        end
    endtask

    task automatic sendBlock(input logic dec, input logic [63:0] blk, input logic [63:0] want);
        @(posedge clk);
        i_valid   <= 1'b1;
        i_decrypt <= dec;
        i_block   <= blk;
        expBlock.push_back(want);
        expMode.push_back(dec);
        expDue.push_back(cycleCount + LATENCY);
    endtask

    // Mode 0 encrypts, 1 decrypts model ciphertexts, 2 mixes both
    task automatic sendRandom(input int count, input int mode);
        logic [63:0] plain;
        logic        dec;
        for (int n = 0; n < count; n++) begin
            plain = {$urandom, $urandom};
            dec   = (mode == 2) ? 1'($urandom % 2) : (mode == 1);
            if (dec) begin
                sendBlock(1'b1, encryptModel(plain), plain);
            end else begin
                sendBlock(1'b0, plain, encryptModel(plain));
            end
        end
    endtask

    task automatic drainPipe();
        @(posedge clk);
        i_valid <= 1'b0;
        while (expDue.size() != 0) begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Four-phase key load
    //////////////////////////////////////////////////

    task automatic loadKey(input logic [127:0] key, input bit noisy);
        int waited;
        bit acked;
        waited = 0;
        acked  = 1'b0;
        expandModelKey(key);
        @(posedge clk);
        i_keyReq <= 1'b1;
        i_key    <= key;
        i_valid  <= 1'b0;
        while (!acked && waited < KEY_CYCLES + 2) begin
            @(posedge clk);
            // Stray blocks during expansion must be dropped
            i_valid <= noisy && waited < KEY_CYCLES - 8 && waited % 5 == 0;
            i_block <= {$urandom, $urandom};
            @(negedge clk);
            waited++;
            acked = o_keyAck;
            if (waited == KEY_CYCLES / 2) begin
                checkBit("o_keyReady during expansion", 1'b0, o_keyReady);
            end
        end
        assert (acked && waited <= KEY_CYCLES) else begin
            $display("[ERROR] %s: o_keyAck not raised within %0d cycles",
                     testName, KEY_CYCLES);
            errCount++;
        end
        checkBit("o_keyReady at ack", 1'b1, o_keyReady);
        repeat (4) begin
            @(negedge clk);
            checkBit("o_keyAck with i_keyReq held", 1'b1, o_keyAck);
        end
        @(posedge clk);
        i_keyReq <= 1'b0;
        waited = 0;
        while (acked && waited < 4) begin
            @(negedge clk);
            waited++;
            acked = o_keyAck;
        end
        assert (!acked) else begin
            $display("[ERROR] %s: o_keyAck stayed high after i_keyReq fell", testName);
            errCount++;
        end
        checkBit("o_keyReady after handshake", 1'b1, o_keyReady);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic resetTest();
        beginTest("reset");
        @(negedge clk);
        checkBit("o_keyAck", 1'b0, o_keyAck);
        checkBit("o_keyReady", 1'b0, o_keyReady);
        checkBit("o_valid", 1'b0, o_valid);
        @(posedge clk);
        i_valid <= 1'b1;
        i_block <= {$urandom, $urandom};
        @(posedge clk);
        i_valid <= 1'b0;
        repeat (LATENCY + 4) @(negedge clk);
        endTest();
    endtask

    task automatic handshakeTest();
        beginTest("key handshake");
        loadKey('0, 1'b0);
        endTest();
    endtask

    task automatic encryptTest();
        beginTest("encrypt");
        // Published RC5-32/12/16 vector for the all-zero key, word A then word B
        sendBlock(1'b0, 64'h0, 64'hEEDBA521_6D8F4B15);
        sendRandom(3, 0);
        drainPipe();
        repeat (2) begin
            loadKey({$urandom, $urandom, $urandom, $urandom}, 1'b0);
            sendRandom(4, 0);
            drainPipe();
        end
        endTest();
    endtask

    task automatic decryptTest();
        beginTest("decrypt");
        sendRandom(6, 1);
        drainPipe();
        endTest();
    endtask

    task automatic streamTest();
        beginTest("stream");
        sendRandom(STREAM_LEN, 2);
        drainPipe();
        endTest();
    endtask

    task automatic reloadTest();
        beginTest("key reload");
        loadKey({$urandom, $urandom, $urandom, $urandom}, 1'b1);
        sendRandom(8, 2);
        drainPipe();
        endTest();
    endtask

    initial begin
        void'($urandom(70));
        clr       = 1'b1;
        i_keyReq  = 1'b0;
        i_key     = '0;
        i_valid   = 1'b0;
        i_decrypt = 1'b0;
        i_block   = '0;
        repeat (3) @(posedge clk);
        clr <= 1'b0;
        resetTest();
        handshakeTest();
        encryptTest();
        decryptTest();
        streamTest();
        reloadTest();
        $display("Summary: %0d tests passed, %0d tests failed", passCount, failCount);
        if (errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rc5Cipher.f */
+incdir+verif
src/rc5Pkg.sv
src/rc5RoundIf.sv
src/rc5KeySchedule.sv
src/rc5Round.sv
src/rc5Pipeline.sv
src/rc5Cipher.sv
verif/rc5CipherTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the RC5 testbench with Verilator, run it and scan the log

verilator --binary --timing --assert -f rc5Cipher.f --top-module rc5CipherTb \
    -o rc5CipherSim > build.log 2>&1 \
    && ./obj_dir/rc5CipherSim | tee sim.log \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

grep -q "Test FAILED" sim.log && exit 1 || exit 0
